// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

  // ------------------------------------------------------------------
  // Sizes and memory map
  // ------------------------------------------------------------------
  localparam int data_w     = 32;
  localparam int regno_w    = 4;
  localparam int imem_words = 16384;
  localparam int dmem_words = 16384;
  localparam int imem_aw    = $clog2(imem_words); // Word index bits
  localparam int dmem_aw    = $clog2(dmem_words);
  localparam int hex_w      = 24;
  localparam int ledr_w     = 10;
  localparam int key_w      = 4;

  typedef logic [data_w-1:0]  word_t;
  typedef logic [regno_w-1:0] regno_t;

  localparam word_t start_pc  = 32'h0000_0100;
  localparam word_t addr_hex  = 32'hFFFF_F000;
  localparam word_t addr_ledr = 32'hFFFF_F020;
  localparam word_t addr_key  = 32'hFFFF_F080;

  localparam logic [hex_w-1:0] hex_reset = 24'hFEDEAD;

  // ------------------------------------------------------------------
  // Opcodes
  // ------------------------------------------------------------------
  typedef enum logic [5:0] {
    ALUR = 6'b000000,
    BEQ  = 6'b001000,
    BLT  = 6'b001001,
    BLE  = 6'b001010,
    BNE  = 6'b001011,
    JAL  = 6'b001100,
    LW   = 6'b010010,
    SW   = 6'b011010,
    ADDI = 6'b100000,
    ANDI = 6'b100100,
    ORI  = 6'b100101,
    XORI = 6'b100110
  } op1_e;

  typedef enum logic [7:0] {
    EQ   = 8'b00001000,
    LT   = 8'b00001001,
    LE   = 8'b00001010,
    NE   = 8'b00001011,
    ADD  = 8'b00100000,
    AND  = 8'b00100100,
    OR   = 8'b00100101,
    XOR  = 8'b00100110,
    SUB  = 8'b00101000,
    NAND = 8'b00101100,
    NOR  = 8'b00101101,
    NXOR = 8'b00101110,
    RSHF = 8'b00110000,
    LSHF = 8'b00110001
  } op2_e;

  // ------------------------------------------------------------------
  // Pipeline latches
  // ------------------------------------------------------------------
  typedef struct packed {
    logic is_br;
    logic is_jmp;
    logic rd_mem;
    logic wr_mem;
    logic wr_reg;
  } ctrl_t;

  typedef struct packed {
    logic   valid;
    word_t  pc_next;  // Own address plus 4
    op1_e   op1;
    op2_e   op2;
    word_t  regval1;
    word_t  regval2;
    word_t  imm;      // Sign-extended
    regno_t wregno;
    ctrl_t  ctrl;
  } id_ex_t;

  typedef struct packed {
    logic   valid;
    word_t  aluout;   // Result or memory address
    word_t  regval2;  // Store data
    regno_t wregno;
    logic   rd_mem;
    logic   wr_mem;
    logic   wr_reg;
  } ex_mem_t;

  typedef struct packed {
    logic   wr_reg;
    regno_t wregno;
    word_t  value;
  } mem_wb_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

  // ------------------------------------------------------------------
  // I/O writes
  // ------------------------------------------------------------------
  typedef enum logic [1:0] {
    IO_HEX,
    IO_LEDR
  } io_target_e;

  typedef struct packed {
    logic       strobe;
    io_target_e target;
    word_t      data;     // Full store word, before truncation
  } io_event_t;

endpackage

// ==== hw/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::regno_t   rs,
  input  cpu_pkg::regno_t   rt,
  input  cpu_pkg::mem_wb_t  mem_wb,
  output cpu_pkg::word_t    rdata1,
  output cpu_pkg::word_t    rdata2
);

  import cpu_pkg::*;

  word_t regs [2**regno_w];

  // Falling-edge write, so decode reads the new value in the same cycle
  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2**regno_w; i++)
        regs[i] <= '0;
    end else if (mem_wb.wr_reg) begin
      regs[mem_wb.wregno] <= mem_wb.value;
    end
  end

  assign rdata1 = regs[rs];
  assign rdata2 = regs[rt];

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage (
  input  logic                clk,
  input  logic                reset,
  input  logic                stall,
  input  cpu_pkg::redirect_t  redirect,
  output cpu_pkg::word_t      inst,
  output cpu_pkg::word_t      pc_next
);

  import cpu_pkg::*;

  word_t pc;
  word_t pc_plus4;
  word_t imem [imem_words];

  initial begin
    $readmemh("prog.hex", imem);
  end

  assign pc_plus4 = pc + 32'd4; // Not-taken prediction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc      <= start_pc;
      inst    <= '0;
      pc_next <= '0;
    end else if (redirect.taken) begin
      pc   <= redirect.target;
      inst <= '0;                 // Bubble, younger fetch is squashed
    end else if (!stall) begin
      pc      <= pc_plus4;
      inst    <= imem[pc[imem_aw+1:2]];
      pc_next <= pc_plus4;
    end
  end

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
  input  logic                clk,
  input  logic                reset,
  input  cpu_pkg::word_t      inst,
  input  cpu_pkg::word_t      pc_next,
  input  cpu_pkg::word_t      rdata1,
  input  cpu_pkg::word_t      rdata2,
  input  logic                stall,
  input  cpu_pkg::redirect_t  redirect,
  output cpu_pkg::regno_t     rs,
  output cpu_pkg::regno_t     rt,
  output logic                uses_rt,
  output cpu_pkg::id_ex_t     id_ex
);

  import cpu_pkg::*;

  op1_e   op1;
  op2_e   op2;
  regno_t rd;
  word_t  imm;
  regno_t wregno;
  ctrl_t  ctrl;
  logic   is_bubble;

  // Field split
  assign op1 = op1_e'(inst[31:26]);
  assign op2 = op2_e'(inst[25:18]);
  assign rd  = inst[11:8];
  assign rs  = inst[7:4];
  assign rt  = inst[3:0];
  assign imm = {{(data_w-16){inst[23]}}, inst[23:8]};

  assign is_bubble = (inst == '0); // Word left by a fetch flush
  assign wregno    = (op1 == ALUR) ? rd : rt;

  always_comb begin
    ctrl    = '0;
    uses_rt = 1'b0;
    case (op1)
      ALUR: begin
        ctrl.wr_reg = 1'b1;
        uses_rt     = 1'b1;
      end
      BEQ, BLT, BLE, BNE: begin
        ctrl.is_br = 1'b1;
        uses_rt    = 1'b1;
      end
      JAL: begin
        ctrl.is_jmp = 1'b1;
        ctrl.wr_reg = 1'b1;
      end
      LW: begin
        ctrl.rd_mem = 1'b1;
        ctrl.wr_reg = 1'b1;
      end
      SW: begin
        ctrl.wr_mem = 1'b1;
        uses_rt     = 1'b1; // Store data
      end
      ADDI, ANDI, ORI, XORI: ctrl.wr_reg = 1'b1;
      default: ctrl = '0;   // Unknown opcode runs as a no-op
    endcase
  end

  // ------------------------------------------------------------------
  // ID/EX latch
  // ------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_ex <= '0;
    end else if (redirect.taken || stall || is_bubble) begin
      id_ex <= '0;
    end else begin
      id_ex.valid   <= 1'b1;
      id_ex.pc_next <= pc_next;
      id_ex.op1     <= op1;
      id_ex.op2     <= op2;
      id_ex.regval1 <= rdata1;
      id_ex.regval2 <= rdata2;
      id_ex.imm     <= imm;
      id_ex.wregno  <= wregno;
      id_ex.ctrl    <= ctrl;
    end
  end

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit (
  input  cpu_pkg::regno_t   rs,
  input  cpu_pkg::regno_t   rt,
  input  logic              uses_rt,
  input  cpu_pkg::id_ex_t   id_ex,
  input  cpu_pkg::ex_mem_t  ex_mem,
  input  cpu_pkg::mem_wb_t  mem_wb,
  output logic              stall
);

  import cpu_pkg::*;

  logic hit_ex;
  logic hit_mem;
  logic hit_wb;

  // True when the decoding instruction reads register w
  function automatic logic reads_reg(regno_t w, regno_t src_s, regno_t src_t,
                                     logic t_used);
    return (w == src_s) || (t_used && (w == src_t));
  endfunction

  // Register 0 is an ordinary register here
  assign hit_ex  = id_ex.valid && id_ex.ctrl.wr_reg &&
                   reads_reg(id_ex.wregno, rs, rt, uses_rt);
  assign hit_mem = ex_mem.valid && ex_mem.wr_reg &&
                   reads_reg(ex_mem.wregno, rs, rt, uses_rt);
  assign hit_wb  = mem_wb.wr_reg &&
                   reads_reg(mem_wb.wregno, rs, rt, uses_rt);

  assign stall = hit_ex || hit_mem || hit_wb; // No forwarding paths

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
  input  logic                clk,
  input  logic                reset,
  input  cpu_pkg::id_ex_t     id_ex,
  output cpu_pkg::ex_mem_t    ex_mem,
  output cpu_pkg::redirect_t  redirect
);

  import cpu_pkg::*;

  word_t a;
  word_t b;
  word_t imm_x4;
  word_t aluout;
  logic  br_cond;
  logic  taken;
  word_t target;

  assign a      = id_ex.regval1;
  assign b      = id_ex.regval2;
  assign imm_x4 = {id_ex.imm[data_w-3:0], 2'b00};

  // ------------------------------------------------------------------
  // ALU
  // ------------------------------------------------------------------
  always_comb begin
    case (id_ex.op1)
      ALUR: begin
        case (id_ex.op2)
          EQ:      aluout = {{(data_w-1){1'b0}}, a == b};
          LT:      aluout = {{(data_w-1){1'b0}}, $signed(a) < $signed(b)};
          LE:      aluout = {{(data_w-1){1'b0}}, $signed(a) <= $signed(b)};
          NE:      aluout = {{(data_w-1){1'b0}}, a != b};
          ADD:     aluout = a + b;
          AND:     aluout = a & b;
          OR:      aluout = a | b;
          XOR:     aluout = a ^ b;
          SUB:     aluout = a - b;
          NAND:    aluout = ~(a & b);
          NOR:     aluout = ~(a | b);
          NXOR:    aluout = ~(a ^ b);
          RSHF:    aluout = $signed(a) >>> b; // Arithmetic
          LSHF:    aluout = a << b;
          default: aluout = '0;
        endcase
      end
      LW, SW, ADDI: aluout = a + id_ex.imm;   // Also the memory address
      ANDI:         aluout = a & id_ex.imm;
      ORI:          aluout = a | id_ex.imm;
      XORI:         aluout = a ^ id_ex.imm;
      JAL:          aluout = id_ex.pc_next;   // Link value
      default:      aluout = '0;
    endcase
  end

  // Branch condition, signed
  always_comb begin
    case (id_ex.op1)
      BEQ:     br_cond = (a == b);
      BLT:     br_cond = ($signed(a) < $signed(b));
      BLE:     br_cond = ($signed(a) <= $signed(b));
      BNE:     br_cond = (a != b);
      default: br_cond = 1'b0;
    endcase
  end

  assign taken  = id_ex.valid && (id_ex.ctrl.is_jmp || (id_ex.ctrl.is_br && br_cond));
  assign target = id_ex.ctrl.is_jmp ? (a + imm_x4) : (id_ex.pc_next + imm_x4);

  // ------------------------------------------------------------------
  // EX/MEM latch and redirect strobe
  // ------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_mem   <= '0;
      redirect <= '0;
    end else if (redirect.taken) begin
      ex_mem   <= '0;   // Squash the instruction behind the branch
      redirect <= '0;
    end else begin
      ex_mem.valid    <= id_ex.valid;
      ex_mem.aluout   <= aluout;
      ex_mem.regval2  <= b;
      ex_mem.wregno   <= id_ex.wregno;
      ex_mem.rd_mem   <= id_ex.ctrl.rd_mem;
      ex_mem.wr_mem   <= id_ex.ctrl.wr_mem;
      ex_mem.wr_reg   <= id_ex.ctrl.wr_reg;
      redirect.taken  <= taken;
      redirect.target <= target;
    end
  end

endmodule

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  cpu_pkg::ex_mem_t           ex_mem,
  input  logic [cpu_pkg::key_w-1:0]  key,
  output cpu_pkg::mem_wb_t           mem_wb
);

  import cpu_pkg::*;

  word_t dmem [dmem_words];
  word_t addr;
  word_t load_data;
  logic  is_io;

  assign addr  = ex_mem.aluout;
  assign is_io = (addr == addr_hex) || (addr == addr_ledr) || (addr == addr_key);

  // KEY buttons are active low
  assign load_data = (addr == addr_key) ? {{(data_w-key_w){1'b0}}, ~key}
                                        : dmem[addr[dmem_aw+1:2]];

  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.wr_mem && !is_io)
      dmem[addr[dmem_aw+1:2]] <= ex_mem.regval2;
  end

  // MEM/WB latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mem_wb <= '0;
    end else begin
      mem_wb.wr_reg <= ex_mem.valid && ex_mem.wr_reg;
      mem_wb.wregno <= ex_mem.wregno;
      mem_wb.value  <= ex_mem.rd_mem ? load_data : ex_mem.aluout;
    end
  end

endmodule

// ==== hw/io_regs.sv ====
`timescale 1ns/1ns

module io_regs (
  input  logic                        clk,
  input  logic                        reset,
  input  cpu_pkg::ex_mem_t            ex_mem,
  output logic [cpu_pkg::hex_w-1:0]   hex,
  output logic [cpu_pkg::ledr_w-1:0]  ledr,
  output cpu_pkg::io_event_t          io_event
);

  import cpu_pkg::*;

  logic store;

  assign store = ex_mem.valid && ex_mem.wr_mem;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex      <= hex_reset;
      ledr     <= '0;
      io_event <= '0;
    end else begin
      io_event <= '0;   // Strobe lasts one cycle
      if (store && (ex_mem.aluout == addr_hex)) begin
        hex      <= ex_mem.regval2[hex_w-1:0];
        io_event <= '{strobe: 1'b1, target: IO_HEX, data: ex_mem.regval2};
      end else if (store && (ex_mem.aluout == addr_ledr)) begin
        ledr     <= ex_mem.regval2[ledr_w-1:0];
        io_event <= '{strobe: 1'b1, target: IO_LEDR, data: ex_mem.regval2};
      end
    end
  end

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [cpu_pkg::key_w-1:0]   key,
  output logic [cpu_pkg::hex_w-1:0]   hex,
  output logic [cpu_pkg::ledr_w-1:0]  ledr,
  output cpu_pkg::io_event_t          io_event
);

  import cpu_pkg::*;

  word_t     inst;
  word_t     pc_next;
  word_t     rdata1;
  word_t     rdata2;
  regno_t    rs;
  regno_t    rt;
  logic      uses_rt;
  logic      stall;
  redirect_t redirect;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  mem_wb_t   mem_wb;

  fetch_stage fetch_stage_inst (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .redirect (redirect),
    .inst     (inst),
    .pc_next  (pc_next)
  );

  decode_stage decode_stage_inst (
    .clk      (clk),
    .reset    (reset),
    .inst     (inst),
    .pc_next  (pc_next),
    .rdata1   (rdata1),
    .rdata2   (rdata2),
    .stall    (stall),
    .redirect (redirect),
    .rs       (rs),
    .rt       (rt),
    .uses_rt  (uses_rt),
    .id_ex    (id_ex)
  );

  hazard_unit hazard_unit_inst (
    .rs      (rs),
    .rt      (rt),
    .uses_rt (uses_rt),
    .id_ex   (id_ex),
    .ex_mem  (ex_mem),
    .mem_wb  (mem_wb),
    .stall   (stall)
  );

  execute_stage execute_stage_inst (
    .clk      (clk),
    .reset    (reset),
    .id_ex    (id_ex),
    .ex_mem   (ex_mem),
    .redirect (redirect)
  );

  mem_stage mem_stage_inst (
    .clk    (clk),
    .reset  (reset),
    .ex_mem (ex_mem),
    .key    (key),
    .mem_wb (mem_wb)
  );

  // Sits beside the memory stage and sees the same EX/MEM latch
  io_regs io_regs_inst (
    .clk      (clk),
    .reset    (reset),
    .ex_mem   (ex_mem),
    .hex      (hex),
    .ledr     (ledr),
    .io_event (io_event)
  );

  reg_file reg_file_inst (
    .clk    (clk),
    .reset  (reset),
    .rs     (rs),
    .rt     (rt),
    .mem_wb (mem_wb),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

endmodule

// ==== verif/cpu_ref_model.svh ====
word_t     ref_imem [imem_words];
io_event_t exp_events [$];        // Expected I/O writes in program order

// Runs prog.hex one instruction at a time and queues every HEX/LEDR write.
// Returns the number of instructions run, or -1 if the closing loop is never hit.
function automatic int build_expected(input logic [key_w-1:0] key_val);
  word_t     regs [16];
  word_t     dmem [word_t];
  word_t     pc;
  word_t     inst;
  word_t     a;
  word_t     b;
  word_t     imm;
  word_t     addr;
  word_t     target;
  regno_t    rd;
  regno_t    rs;
  regno_t    rt;
  op1_e      op1;
  op2_e      op2;
  logic      take;
  io_event_t ev;
  int        steps;

  $readmemh("prog.hex", ref_imem);
  for (int i = 0; i < 16; i++)
    regs[i] = '0;
  exp_events.delete();
  pc    = start_pc;
  steps = 0;

  while (steps < 100000) begin
    inst   = ref_imem[pc[imem_aw+1:2]];
    op1    = op1_e'(inst[31:26]);
    op2    = op2_e'(inst[25:18]);
    rd     = inst[11:8];
    rs     = inst[7:4];
    rt     = inst[3:0];
    a      = regs[rs];
    b      = regs[rt];
    imm    = {{16{inst[23]}}, inst[23:8]};
    addr   = a + imm;
    target = pc + 32'd4 + (imm << 2);
    take   = 1'b0;
    steps++;

    case (op1)
      ALUR: begin
        case (op2)
          EQ:   regs[rd] = (a == b) ? 32'd1 : 32'd0;
          LT:   regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          LE:   regs[rd] = ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
          NE:   regs[rd] = (a != b) ? 32'd1 : 32'd0;
          ADD:  regs[rd] = a + b;
          AND:  regs[rd] = a & b;
          OR:   regs[rd] = a | b;
          XOR:  regs[rd] = a ^ b;
          SUB:  regs[rd] = a - b;
          NAND: regs[rd] = ~(a & b);
          NOR:  regs[rd] = ~(a | b);
          NXOR: regs[rd] = ~(a ^ b);
          RSHF: regs[rd] = $signed(a) >>> b;
          LSHF: regs[rd] = a << b;
          default: ;
        endcase
      end
      BEQ:  take = (a == b);
      BLT:  take = ($signed(a) < $signed(b));
      BLE:  take = ($signed(a) <= $signed(b));
      BNE:  take = (a != b);
      JAL: begin
        target   = a + (imm << 2);  // Read rs before the link lands
        regs[rt] = pc + 32'd4;
        take     = 1'b1;
      end
      LW: begin
        if (addr == addr_key)
          regs[rt] = {{(data_w-key_w){1'b0}}, ~key_val};
        else if (dmem.exists(addr))
          regs[rt] = dmem[addr];
        else
          regs[rt] = '0;
      end
      SW: begin
        ev.strobe = 1'b1;
        ev.data   = b;
        if (addr == addr_hex) begin
          ev.target = IO_HEX;
          exp_events.push_back(ev);
        end else if (addr == addr_ledr) begin
          ev.target = IO_LEDR;
          exp_events.push_back(ev);
        end else if (addr != addr_key) begin
          dmem[addr] = b;
        end
      end
      ADDI: regs[rt] = a + imm;
      ANDI: regs[rt] = a & imm;
      ORI:  regs[rt] = a | imm;
      XORI: regs[rt] = a ^ imm;
      default: ;                     // No-op
    endcase

    if (take && (target == pc))
      return steps;                  // Closing self-loop
    pc = take ? target : pc + 32'd4;
  end
  return -1;
endfunction

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb;

  import cpu_pkg::*;

  localparam int clk_period = 8;

  logic               clk;
  logic               reset;
  logic [key_w-1:0]   key;
  logic [hex_w-1:0]   hex;
  logic [ledr_w-1:0]  ledr;
  io_event_t          io_event;

  int                 seed = 32'ha3019f73;
  logic [key_w-1:0]   key_val;
  int                 limit_cycles = 0;

  `include "cpu_ref_model.svh"

  cpu_top cpu_top_inst (
    .clk      (clk),
    .reset    (reset),
    .key      (key),
    .hex      (hex),
    .ledr     (ledr),
    .io_event (io_event)
  );

  always #(clk_period/2) clk = ~clk;

  // ------------------------------------------------------------------
  // Result checks
  // ------------------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_event(input io_event_t got, input io_event_t exp, input int idx);
    if (got !== exp)
      abort_run($sformatf("FAIL at %0t: event %0d is %s 0x%08h, expected %s 0x%08h",
                          $time, idx, got.target.name(), got.data,
                          exp.target.name(), exp.data));
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp)
      abort_run($sformatf("FAIL at %0t: %s is 0x%08h, expected 0x%08h",
                          $time, what, got, exp));
  endtask

  // ------------------------------------------------------------------
  // Stimulus and comparison
  // ------------------------------------------------------------------
  initial begin
    int        idx;
    int        steps;
    io_event_t exp;

    clk     = 1'b0;
    reset   = 1'b1;
    key     = '0;
    key_val = key_w'($random(seed));

    steps = build_expected(key_val);
    if (steps < 0)
      abort_run("Reference model never reached the closing loop of prog.hex");
    limit_cycles = 20 * exp_events.size() + 200;

    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    key <= key_val;                   // Held for the rest of the run

    @(negedge clk);
    check_word("hex after reset", {8'h00, hex}, 32'h00FE_DEAD);
    check_word("ledr after reset", {22'h0, ledr}, '0);
    check_word("strobe after reset", {31'h0, io_event.strobe}, '0);

    idx = 0;
    while (idx < exp_events.size()) begin
      @(negedge clk);
      if (io_event.strobe) begin
        exp = exp_events[idx];
        check_event(io_event, exp, idx);
        if (exp.target == IO_HEX)
          check_word("hex", {8'h00, hex}, {8'h00, exp.data[hex_w-1:0]});
        else
          check_word("ledr", {22'h0, ledr}, {22'h0, exp.data[ledr_w-1:0]});
        idx++;
      end
    end

    // Nothing may write once the program sits in its loop
    repeat (50) begin
      @(negedge clk);
      if (io_event.strobe)
        abort_run($sformatf("FAIL at %0t: extra %s write 0x%08h", $time,
                            io_event.target.name(), io_event.data));
    end

    $display("=== PASS ===");
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_cycles > 0);
    #(limit_cycles * clk_period);
    abort_run($sformatf("Run timed out after %0d cycles without seeing every I/O write",
                        limit_cycles));
  end

endmodule

// ==== prog.hex ====
// One 32-bit instruction word per line, loaded at word index 0x40 (PC 0x100)
// Comments give the PC and the operation
@40
80000701 // 100 addi r1 = 7
80FFFD02 // 104 addi r2 = -3
00800312 // 108 add  r3 = r1 + r2
68F00003 // 10C sw   hex = r3
00A00412 // 110 sub  r4 = r1 - r2
00900512 // 114 and  r5
00940645 // 118 or   r6 = r4 | r5
00980761 // 11C xor  r7 = r6 ^ r1
00B00812 // 120 nand r8
00B40914 // 124 nor  r9
00B80A12 // 128 nxor r10
68F02004 // 12C sw   ledr = r4
68F00005 // 130 sw   hex = r5
68F00006 // 134 sw   hex = r6
68F02007 // 138 sw   ledr = r7
68F00008 // 13C sw   hex = r8
68F02009 // 140 sw   ledr = r9
68F0000A // 144 sw   hex = r10
00240B21 // 148 lt   r11 = r2 < r1
00280C12 // 14C le   r12 = r1 <= r2
00200D11 // 150 eq   r13 = r1 == r1
002C0E12 // 154 ne   r14 = r1 != r2
68F0200B // 158 sw   ledr = r11
68F0200C // 15C sw   ledr = r12
68F0200D // 160 sw   ledr = r13
68F0200E // 164 sw   ledr = r14
8000020F // 168 addi r15 = 2
00C00B8F // 16C rshf r11 = r8 >>> r15
00C40C1F // 170 lshf r12 = r1 << r15
68F0000B // 174 sw   hex = r11
68F0000C // 178 sw   hex = r12
9000FF83 // 17C andi r3 = r8 & 0xff
94800034 // 180 ori  r4 = r3 | 0xffff8000
98123445 // 184 xori r5 = r4 ^ 0x1234
68F00005 // 188 sw   hex = r5
80004006 // 18C addi r6 = 0x40
68000464 // 190 sw   mem[r6+4] = r4
48000467 // 194 lw   r7 = mem[r6+4]
68F00007 // 198 sw   hex = r7
48F08008 // 19C lw   r8 = key
68F02008 // 1A0 sw   ledr = r8
20000112 // 1A4 beq  r1, r2 not taken
68F02001 // 1A8 sw   ledr = r1
24000121 // 1AC blt  r2, r1 taken
68F00002 // 1B0 skipped
24000112 // 1B4 blt  r1, r2 not taken
68F00001 // 1B8 sw   hex = r1
28000211 // 1BC ble  r1, r1 taken
68F00009 // 1C0 skipped
68F02009 // 1C4 skipped
28000112 // 1C8 ble  r1, r2 not taken
2C000111 // 1CC bne  r1, r1 not taken
2C000112 // 1D0 bne  r1, r2 taken
68F00002 // 1D4 skipped
20000122 // 1D8 beq  r2, r2 taken
68F02002 // 1DC skipped
3000800D // 1E0 jal  r13, 0x200
68F0200F // 1E4 sw   ledr = r15
20FFFF00 // 1E8 loop forever
00000000
00000000
00000000
@80
8001230E // 200 addi r14 = 0x123
68F0000E // 204 sw   hex = r14
300000DC // 208 jal  r12, r13 (return)
00000000
00000000
00000000

// ==== vlog.f ====
+incdir+verif
hw/cpu_pkg.sv
hw/reg_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/mem_stage.sv
hw/io_regs.sv
hw/cpu_top.sv
verif/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f vlog.f --top-module cpu_tb -o cpu_tb_sim &&
./obj_dir/cpu_tb_sim || exit 1
